// ==== design/bridge_cfg_pkg.sv ====
package bridge_cfg_pkg;

  localparam int BUS_ADDR_W = 23;     // word address on the bus
  localparam int BUS_DATA_W = 32;
  localparam int BYTE_EN_W = 4;

  localparam int SDRAM_ADDR_W = 24;   // 16-bit word address, bus word times two
  localparam int SDRAM_DATA_W = 16;
  localparam int BURST_W = 10;

  localparam int LIFE_W = 16;
  localparam int LIFE_START = 512;    // life of a freshly claimed slot
  localparam int LIFE_CEILING = 10000;

  localparam int DEF_SLOT_COUNT = 4;
  localparam int DEF_PAGE_WORDS_LOG2 = 4;
  localparam int DEF_LINE_BURSTS = 4;
  localparam int DEF_BURST_BEATS = 16;

  localparam int LINE_ADDR_W = 16;

endpackage

// ==== design/bridge_types_pkg.sv ====
package bridge_types_pkg;

  typedef struct packed {
    logic                                  is_write;
    logic [bridge_cfg_pkg::BUS_ADDR_W-1:0] addr;
    logic [bridge_cfg_pkg::BUS_DATA_W-1:0] wdata;
    logic [bridge_cfg_pkg::BYTE_EN_W-1:0]  wmask;  // set bit leaves the byte untouched
  } word_req_t;

  typedef struct packed {
    logic [bridge_cfg_pkg::SDRAM_ADDR_W-1:0] addr;
    logic [bridge_cfg_pkg::BURST_W-1:0]      beats;
  } line_burst_t;

  typedef struct packed {
    logic [bridge_cfg_pkg::BURST_W-1:0]      index;  // position within the line
    logic [bridge_cfg_pkg::SDRAM_DATA_W-1:0] data;
  } line_word_t;

  typedef struct packed {
    logic [bridge_cfg_pkg::SDRAM_ADDR_W-1:0] addr;
    logic [bridge_cfg_pkg::BURST_W-1:0]      burst_len;
    logic                                    rd_req;
    logic                                    wr_req;
    logic [1:0]                              mask;
  } sdram_cmd_t;

  typedef enum logic [2:0] {
    IDLE,
    EVICT_SCAN,
    EVICT_WRITE,
    FILL_READ,
    DIRECT_READ,
    DIRECT_WRITE,
    FINISH
  } cache_state_e;

  typedef enum logic [1:0] {
    GRANT_NONE,
    GRANT_LINE,
    GRANT_WORD
  } grant_e;

endpackage

// ==== design/word_cache.sv ====
`timescale 1ns/1ps

module word_cache #(
  parameter int SLOT_COUNT = bridge_cfg_pkg::DEF_SLOT_COUNT,
  parameter int PAGE_WORDS_LOG2 = bridge_cfg_pkg::DEF_PAGE_WORDS_LOG2
) (
  input  logic                                  clk,
  input  logic                                  sys_rst_n,
  input  logic                                  bus_read,
  input  logic                                  bus_write,
  input  logic [bridge_cfg_pkg::BUS_ADDR_W-1:0] bus_address,
  input  logic [bridge_cfg_pkg::BUS_DATA_W-1:0] bus_writedata,
  input  logic [bridge_cfg_pkg::BYTE_EN_W-1:0]  bus_byteenable,
  output logic [bridge_cfg_pkg::BUS_DATA_W-1:0] bus_readdata,
  output logic                                  bus_waitrequest,
  output logic                                  word_req,
  output bridge_types_pkg::word_req_t           word_req_data,
  input  logic                                  word_ack,
  input  logic [bridge_cfg_pkg::BUS_DATA_W-1:0] word_rdata
);
  import bridge_cfg_pkg::*;
  import bridge_types_pkg::*;

  localparam int PAGE_WORDS = 1 << PAGE_WORDS_LOG2;
  localparam int TAG_W = BUS_ADDR_W - PAGE_WORDS_LOG2;
  localparam int SLOT_W = (SLOT_COUNT > 1) ? $clog2(SLOT_COUNT) : 1;
  localparam logic [LIFE_W-1:0] LIFE_GAIN = LIFE_W'(2 * SLOT_COUNT);

  cache_state_e               state;
  logic [SLOT_W-1:0]          slot;       // slot held by the running access
  logic [PAGE_WORDS_LOG2-1:0] scan_idx;   // write-back position
  logic                       bus_done;

  logic [BUS_DATA_W-1:0] mem [SLOT_COUNT][PAGE_WORDS];
  logic [TAG_W-1:0]      tag [SLOT_COUNT];
  logic [SLOT_COUNT-1:0] tag_valid;
  logic [PAGE_WORDS-1:0] word_valid [SLOT_COUNT];
  logic [PAGE_WORDS-1:0] word_dirty [SLOT_COUNT];
  logic [LIFE_W-1:0]     life [SLOT_COUNT];

  wire [TAG_W-1:0]           page = bus_address[BUS_ADDR_W-1:PAGE_WORDS_LOG2];
  wire [PAGE_WORDS_LOG2-1:0] offset = bus_address[PAGE_WORDS_LOG2-1:0];
  wire                       bus_req = bus_read | bus_write;

  logic                  hit;
  logic                  free_any;
  logic [SLOT_W-1:0]     hit_slot;
  logic [SLOT_W-1:0]     free_slot;
  logic [SLOT_W-1:0]     sel_slot;
  logic [BUS_DATA_W-1:0] cur_word;
  logic [BUS_DATA_W-1:0] fill_word;
  logic [BUS_DATA_W-1:0] new_word;
  logic                  hit_ok;
  logic                  cached;
  logic                  complete;
  logic                  mem_we;
  logic                  claim;
  logic                  wb_ack;

  function automatic logic [BUS_DATA_W-1:0] merge_bytes(
    input logic [BYTE_EN_W-1:0]  be,
    input logic [BUS_DATA_W-1:0] wd,
    input logic [BUS_DATA_W-1:0] old
  );
    logic [BUS_DATA_W-1:0] res;
    for (int b = 0; b < BYTE_EN_W; b++) begin
      res[8*b +: 8] = be[b] ? wd[8*b +: 8] : old[8*b +: 8];
    end
    return res;
  endfunction

  assign bus_waitrequest = bus_req && !bus_done;

  // tag match and first free slot, lowest index wins
  always_comb begin
    hit = 1'b0;
    hit_slot = '0;
    free_any = 1'b0;
    free_slot = '0;
    for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
      if (tag_valid[i] && tag[i] == page) begin
        hit = 1'b1;
        hit_slot = SLOT_W'(i);
      end
      if (life[i] == '0) begin
        free_any = 1'b1;
        free_slot = SLOT_W'(i);
      end
    end
  end

  always_comb begin
    if (state != IDLE) sel_slot = slot;
    else sel_slot = hit ? hit_slot : free_slot;
    cur_word = mem[sel_slot][offset];
    hit_ok = hit && (word_valid[hit_slot][offset] || (bus_write && &bus_byteenable));
    cached = !(state inside {DIRECT_READ, DIRECT_WRITE});
    complete = (state == IDLE && bus_req && hit_ok) ||
               (word_ack && state inside {FILL_READ, DIRECT_READ, DIRECT_WRITE});
    fill_word = (state == FILL_READ) ? word_rdata : cur_word;
    new_word = bus_write ? merge_bytes(bus_byteenable, bus_writedata, fill_word) : word_rdata;
    mem_we = (state == IDLE && bus_req && hit_ok && bus_write) ||
             (state == FILL_READ && word_ack);
    claim = (state == IDLE && bus_req && !hit && free_any && !tag_valid[free_slot]) ||
            (state == EVICT_SCAN && !word_dirty[slot][scan_idx] && &scan_idx);
    wb_ack = (state == EVICT_WRITE) && word_ack;
  end

  always_ff @(posedge clk) begin
    if (mem_we) mem[sel_slot][offset] <= new_word;
    if (claim) tag[sel_slot] <= page;
  end

  // flags and life counters
  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      tag_valid <= '0;
      for (int i = 0; i < SLOT_COUNT; i++) begin
        word_valid[i] <= '0;
        word_dirty[i] <= '0;
        life[i] <= '0;
      end
    end else begin
      if (complete) begin
        for (int i = 0; i < SLOT_COUNT; i++) begin
          if (cached && SLOT_W'(i) == sel_slot) begin
            if (life[i] < LIFE_W'(LIFE_CEILING)) life[i] <= life[i] + LIFE_GAIN;
          end else if (life[i] != '0) begin
            life[i] <= life[i] - 1'b1;
          end
        end
      end
      if (mem_we) begin
        word_valid[sel_slot][offset] <= 1'b1;
        word_dirty[sel_slot][offset] <= bus_write;
      end
      if (wb_ack) word_dirty[slot][scan_idx] <= 1'b0;
      if (claim) begin
        tag_valid[sel_slot] <= 1'b1;
        word_valid[sel_slot] <= '0;
        word_dirty[sel_slot] <= '0;
        life[sel_slot] <= LIFE_W'(LIFE_START);
      end
    end
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state <= IDLE;
      slot <= '0;
      scan_idx <= '0;
      bus_done <= 1'b0;
      bus_readdata <= '0;
      word_req <= 1'b0;
      word_req_data <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (bus_req) begin
            slot <= sel_slot;
            scan_idx <= '0;
            if (hit_ok) begin
              bus_readdata <= cur_word;
              bus_done <= 1'b1;
              state <= FINISH;
            end else if (hit) begin  // word not present yet
              word_req <= 1'b1;
              word_req_data <= '{is_write: 1'b0, addr: bus_address, wdata: '0, wmask: '0};
              state <= FILL_READ;
            end else if (free_any) begin
              // an empty slot is claimed now and retried as a hit
              if (tag_valid[free_slot]) state <= EVICT_SCAN;
            end else begin
              word_req <= 1'b1;
              word_req_data <= '{is_write: bus_write, addr: bus_address,
                                 wdata: bus_writedata, wmask: ~bus_byteenable};
              state <= bus_write ? DIRECT_WRITE : DIRECT_READ;
            end
          end
        end
        EVICT_SCAN: begin
          if (word_dirty[slot][scan_idx]) begin
            word_req <= 1'b1;
            word_req_data <= '{is_write: 1'b1, addr: {tag[slot], scan_idx},
                               wdata: mem[slot][scan_idx], wmask: '0};
            state <= EVICT_WRITE;
          end else if (&scan_idx) begin
            state <= IDLE;  // page clean, new tag taken
          end else begin
            scan_idx <= scan_idx + 1'b1;
          end
        end
        EVICT_WRITE: begin
          if (word_ack) begin
            word_req <= 1'b0;
            state <= EVICT_SCAN;
          end
        end
        FILL_READ, DIRECT_READ, DIRECT_WRITE: begin
          if (word_ack) begin
            word_req <= 1'b0;
            bus_readdata <= word_rdata;
            bus_done <= 1'b1;
            state <= FINISH;
          end
        end
        FINISH: begin
          if (!bus_req) begin  // master released the request
            bus_done <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// ==== design/line_fetcher.sv ====
`timescale 1ns/1ps

module line_fetcher #(
  parameter int LINE_BURSTS = bridge_cfg_pkg::DEF_LINE_BURSTS,
  parameter int BURST_BEATS = bridge_cfg_pkg::DEF_BURST_BEATS
) (
  input  logic                                    clk,
  input  logic                                    sys_rst_n,
  input  logic                                    line_req,
  input  logic [bridge_cfg_pkg::LINE_ADDR_W-1:0]  line_addr,
  input  logic                                    beat_valid,
  input  logic [bridge_cfg_pkg::SDRAM_DATA_W-1:0] beat_data,
  input  logic                                    burst_ack,
  output logic                                    burst_req,
  output bridge_types_pkg::line_burst_t           burst_cmd,
  output bridge_types_pkg::line_word_t            line_word,
  output logic                                    line_word_valid,
  output logic                                    line_done
);
  import bridge_cfg_pkg::*;
  import bridge_types_pkg::*;

  localparam int LINE_WORDS = LINE_BURSTS * BURST_BEATS;
  localparam int BI_W = (LINE_BURSTS > 1) ? $clog2(LINE_BURSTS) : 1;

  logic [BI_W-1:0]    burst_idx;
  logic [BURST_W-1:0] word_idx;   // index of the next beat in the line

  assign burst_cmd = '{
    addr:  SDRAM_ADDR_W'(line_addr) * SDRAM_ADDR_W'(LINE_WORDS) +
           SDRAM_ADDR_W'(burst_idx) * SDRAM_ADDR_W'(BURST_BEATS),
    beats: BURST_W'(BURST_BEATS)
  };

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      burst_req <= 1'b0;
      burst_idx <= '0;
      word_idx <= '0;
      line_word <= '0;
      line_word_valid <= 1'b0;
      line_done <= 1'b0;
    end else begin
      line_word_valid <= beat_valid;
      if (beat_valid) begin
        line_word <= '{index: word_idx, data: beat_data};
        word_idx <= word_idx + 1'b1;
      end
      if (!burst_req && !line_done && line_req) begin  // new line
        burst_req <= 1'b1;
        burst_idx <= '0;
        word_idx <= '0;
      end
      if (burst_ack) begin
        if (burst_idx == BI_W'(LINE_BURSTS - 1)) begin
          burst_req <= 1'b0;
          line_done <= 1'b1;
        end else begin
          burst_idx <= burst_idx + 1'b1;
        end
      end
      if (line_done && !line_req) line_done <= 1'b0;
    end
  end

endmodule

// ==== design/sdram_port_arbiter.sv ====
`timescale 1ns/1ps

module sdram_port_arbiter #(
  parameter int BURST_BEATS = bridge_cfg_pkg::DEF_BURST_BEATS
) (
  input  logic                                    clk,
  input  logic                                    sys_rst_n,
  input  logic                                    burst_req,
  input  bridge_types_pkg::line_burst_t           burst_cmd,
  input  logic                                    word_req,
  input  bridge_types_pkg::word_req_t             word_req_data,
  input  logic                                    sdram_rd_ack,
  input  logic                                    sdram_wr_ack,
  input  logic [bridge_cfg_pkg::SDRAM_DATA_W-1:0] sdram_dout,
  output logic                                    beat_valid,
  output logic [bridge_cfg_pkg::SDRAM_DATA_W-1:0] beat_data,
  output logic                                    burst_ack,
  output logic                                    word_ack,
  output logic [bridge_cfg_pkg::BUS_DATA_W-1:0]   word_rdata,
  output bridge_types_pkg::sdram_cmd_t            sdram_cmd,
  output logic [bridge_cfg_pkg::SDRAM_DATA_W-1:0] sdram_din
);
  import bridge_cfg_pkg::*;
  import bridge_types_pkg::*;

  grant_e             owner;
  logic [BURST_W-1:0] beat_cnt;

  wire any_ack = sdram_rd_ack | sdram_wr_ack;
  // requesters update in the ack cycle, so no grant then
  wire idle = (owner == GRANT_NONE) && !burst_ack && !word_ack;

  assign beat_valid = (owner == GRANT_LINE) && sdram_rd_ack;
  assign beat_data = sdram_dout;

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      owner <= GRANT_NONE;
      beat_cnt <= '0;
      burst_ack <= 1'b0;
      word_ack <= 1'b0;
      word_rdata <= '0;
      sdram_cmd <= '0;
      sdram_din <= '0;
    end else begin
      burst_ack <= 1'b0;
      word_ack <= 1'b0;
      case (owner)
        GRANT_NONE: begin
          beat_cnt <= '0;
          if (idle && burst_req) begin  // line has priority
            owner <= GRANT_LINE;
            sdram_cmd <= '{addr: burst_cmd.addr, burst_len: burst_cmd.beats,
                           rd_req: 1'b1, wr_req: 1'b0, mask: 2'b00};
          end else if (idle && word_req) begin
            owner <= GRANT_WORD;
            sdram_cmd <= '{addr: {word_req_data.addr, 1'b0}, burst_len: BURST_W'(2),
                           rd_req: !word_req_data.is_write, wr_req: word_req_data.is_write,
                           mask: word_req_data.wmask[1:0]};
            sdram_din <= word_req_data.wdata[SDRAM_DATA_W-1:0];  // low half first
          end
        end
        GRANT_LINE: begin
          if (sdram_rd_ack) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == BURST_W'(BURST_BEATS - 1)) begin
              sdram_cmd.rd_req <= 1'b0;
              owner <= GRANT_NONE;
              burst_ack <= 1'b1;
            end
          end
        end
        GRANT_WORD: begin
          if (any_ack) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == '0) begin
              word_rdata[SDRAM_DATA_W-1:0] <= sdram_dout;
              sdram_din <= word_req_data.wdata[BUS_DATA_W-1:SDRAM_DATA_W];
              sdram_cmd.mask <= word_req_data.wmask[3:2];
            end else begin
              word_rdata[BUS_DATA_W-1:SDRAM_DATA_W] <= sdram_dout;
              sdram_cmd.rd_req <= 1'b0;
              sdram_cmd.wr_req <= 1'b0;
              owner <= GRANT_NONE;
              word_ack <= 1'b1;
            end
          end
        end
        default: owner <= GRANT_NONE;
      endcase
    end
  end

endmodule

// ==== design/sdram_cache_bridge.sv ====
`timescale 1ns/1ps

module sdram_cache_bridge #(
  parameter int SLOT_COUNT = bridge_cfg_pkg::DEF_SLOT_COUNT,
  parameter int PAGE_WORDS_LOG2 = bridge_cfg_pkg::DEF_PAGE_WORDS_LOG2,
  parameter int LINE_BURSTS = bridge_cfg_pkg::DEF_LINE_BURSTS,
  parameter int BURST_BEATS = bridge_cfg_pkg::DEF_BURST_BEATS
) (
  input  logic                                    clk,
  input  logic                                    sys_rst_n,
  input  logic [bridge_cfg_pkg::BUS_ADDR_W-1:0]   bus_address,
  input  logic                                    bus_read,
  input  logic                                    bus_write,
  input  logic [bridge_cfg_pkg::BUS_DATA_W-1:0]   bus_writedata,
  input  logic [bridge_cfg_pkg::BYTE_EN_W-1:0]    bus_byteenable,
  output logic [bridge_cfg_pkg::BUS_DATA_W-1:0]   bus_readdata,
  output logic                                    bus_waitrequest,
  input  logic                                    line_req,
  input  logic [bridge_cfg_pkg::LINE_ADDR_W-1:0]  line_addr,
  output bridge_types_pkg::line_word_t            line_word,
  output logic                                    line_word_valid,
  output logic                                    line_done,
  output bridge_types_pkg::sdram_cmd_t            sdram_cmd,
  output logic [bridge_cfg_pkg::SDRAM_DATA_W-1:0] sdram_din,
  input  logic                                    sdram_rd_ack,
  input  logic                                    sdram_wr_ack,
  input  logic [bridge_cfg_pkg::SDRAM_DATA_W-1:0] sdram_dout
);

  logic                                    word_req;
  bridge_types_pkg::word_req_t             word_req_data;
  logic                                    word_ack;
  logic [bridge_cfg_pkg::BUS_DATA_W-1:0]   word_rdata;
  logic                                    burst_req;
  bridge_types_pkg::line_burst_t           burst_cmd;
  logic                                    burst_ack;
  logic                                    beat_valid;
  logic [bridge_cfg_pkg::SDRAM_DATA_W-1:0] beat_data;

  word_cache #(
    .SLOT_COUNT      (SLOT_COUNT),
    .PAGE_WORDS_LOG2 (PAGE_WORDS_LOG2)
  ) u_word_cache (
    .clk             (clk),
    .sys_rst_n       (sys_rst_n),
    .bus_read        (bus_read),
    .bus_write       (bus_write),
    .bus_address     (bus_address),
    .bus_writedata   (bus_writedata),
    .bus_byteenable  (bus_byteenable),
    .bus_readdata    (bus_readdata),
    .bus_waitrequest (bus_waitrequest),
    .word_req        (word_req),
    .word_req_data   (word_req_data),
    .word_ack        (word_ack),
    .word_rdata      (word_rdata)
  );

  line_fetcher #(
    .LINE_BURSTS     (LINE_BURSTS),
    .BURST_BEATS     (BURST_BEATS)
  ) u_line_fetcher (
    .clk             (clk),
    .sys_rst_n       (sys_rst_n),
    .line_req        (line_req),
    .line_addr       (line_addr),
    .beat_valid      (beat_valid),
    .beat_data       (beat_data),
    .burst_ack       (burst_ack),
    .burst_req       (burst_req),
    .burst_cmd       (burst_cmd),
    .line_word       (line_word),
    .line_word_valid (line_word_valid),
    .line_done       (line_done)
  );

  sdram_port_arbiter #(
    .BURST_BEATS     (BURST_BEATS)
  ) u_sdram_port_arbiter (
    .clk             (clk),
    .sys_rst_n       (sys_rst_n),
    .burst_req       (burst_req),
    .burst_cmd       (burst_cmd),
    .word_req        (word_req),
    .word_req_data   (word_req_data),
    .sdram_rd_ack    (sdram_rd_ack),
    .sdram_wr_ack    (sdram_wr_ack),
    .sdram_dout      (sdram_dout),
    .beat_valid      (beat_valid),
    .beat_data       (beat_data),
    .burst_ack       (burst_ack),
    .word_ack        (word_ack),
    .word_rdata      (word_rdata),
    .sdram_cmd       (sdram_cmd),
    .sdram_din       (sdram_din)
  );

endmodule

// ==== verification/sdram_model.sv ====
`timescale 1ns/1ps

module sdram_model #(
  parameter int MEM_ADDR_W = 15,
  parameter int LATENCY = 3
) (
  input  logic                                    clk,
  input  logic                                    sys_rst_n,
  input  bridge_types_pkg::sdram_cmd_t            sdram_cmd,
  input  logic [bridge_cfg_pkg::SDRAM_DATA_W-1:0] sdram_din,
  output logic                                    sdram_rd_ack,
  output logic                                    sdram_wr_ack,
  output logic [bridge_cfg_pkg::SDRAM_DATA_W-1:0] sdram_dout
);
  import bridge_cfg_pkg::*;
  import bridge_types_pkg::*;

  logic [SDRAM_DATA_W-1:0] mem [1 << MEM_ADDR_W];
  logic                    busy;
  logic                    gap;        // one free cycle between bursts
  int                      wait_cnt;
  logic [BURST_W-1:0]      beat;
  logic [MEM_ADDR_W-1:0]   ack_addr;   // word acked in the current cycle

  wire [MEM_ADDR_W-1:0] beat_addr = MEM_ADDR_W'(sdram_cmd.addr + beat);

  task automatic preload(input int idx, input logic [SDRAM_DATA_W-1:0] data);
    mem[idx] = data;
  endtask

  always @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      busy <= 1'b0;
      gap <= 1'b0;
      wait_cnt <= 0;
      beat <= '0;
      ack_addr <= '0;
      sdram_rd_ack <= 1'b0;
      sdram_wr_ack <= 1'b0;
      sdram_dout <= '0;
    end else begin
      sdram_rd_ack <= 1'b0;
      sdram_wr_ack <= 1'b0;
      if (sdram_wr_ack) begin  // din and mask belong to the acked beat
        mem[ack_addr] <= {sdram_cmd.mask[1] ? mem[ack_addr][15:8] : sdram_din[15:8],
                          sdram_cmd.mask[0] ? mem[ack_addr][7:0] : sdram_din[7:0]};
      end
      if (!busy) begin
        gap <= 1'b0;
        if (!gap && (sdram_cmd.rd_req || sdram_cmd.wr_req)) begin
          busy <= 1'b1;
          wait_cnt <= LATENCY;  // slow start stretches the ack wait
          beat <= '0;
        end
      end else if (wait_cnt != 0) begin
        wait_cnt <= wait_cnt - 1;
      end else if (beat < sdram_cmd.burst_len) begin
        sdram_rd_ack <= sdram_cmd.rd_req;
        sdram_wr_ack <= sdram_cmd.wr_req;
        sdram_dout <= mem[beat_addr];
        ack_addr <= beat_addr;
        beat <= beat + 1'b1;
      end else begin
        busy <= 1'b0;
        gap <= 1'b1;
      end
    end
  end

endmodule

// ==== verification/tb_sdram_cache_bridge.sv ====
`timescale 1ns/1ps

module tb_sdram_cache_bridge;
  import bridge_cfg_pkg::*;
  import bridge_types_pkg::*;

  localparam int SLOT_COUNT = 4;
  localparam int PAGE_WORDS_LOG2 = 4;
  localparam int LINE_BURSTS = 4;
  localparam int BURST_BEATS = 16;
  localparam int PAGE_WORDS = 1 << PAGE_WORDS_LOG2;
  localparam int LINE_WORDS = LINE_BURSTS * BURST_BEATS;
  localparam int MEM_ADDR_W = 15;
  localparam int MEM_WORDS = 1 << MEM_ADDR_W;
  localparam int OVF_PAGE0 = 3;        // first of the six overflow pages
  localparam int ACCESS_COUNT = 36;    // bus accesses over all tests
  localparam int EVICT_WORST = 4 * 16 * 8;
  localparam int TIMEOUT_CYCLES = ACCESS_COUNT * EVICT_WORST + 1568;  // margin for lines

  logic                    clk;
  logic                    sys_rst_n;
  logic [BUS_ADDR_W-1:0]   bus_address;
  logic                    bus_read;
  logic                    bus_write;
  logic [BUS_DATA_W-1:0]   bus_writedata;
  logic [BYTE_EN_W-1:0]    bus_byteenable;
  logic [BUS_DATA_W-1:0]   bus_readdata;
  logic                    bus_waitrequest;
  logic                    line_req;
  logic [LINE_ADDR_W-1:0]  line_addr;
  line_word_t              line_word;
  logic                    line_word_valid;
  logic                    line_done;
  sdram_cmd_t              sdram_cmd;
  logic [SDRAM_DATA_W-1:0] sdram_din;
  logic                    sdram_rd_ack;
  logic                    sdram_wr_ack;
  logic [SDRAM_DATA_W-1:0] sdram_dout;

  logic [SDRAM_DATA_W-1:0] shadow16 [MEM_WORDS];  // expected SDRAM contents
  logic [31:0]             lfsr_state = 32'h95a6e6f8;
  int                      ref_tag [SLOT_COUNT];
  bit                      ref_tagged [SLOT_COUNT];
  int                      ref_life [SLOT_COUNT];
  int                      err_count = 0;
  int                      check_count = 0;
  int                      test_count = 0;
  int                      test_err_base = 0;
  int                      cycle_count = 0;

  sdram_cache_bridge #(
    .SLOT_COUNT      (SLOT_COUNT),
    .PAGE_WORDS_LOG2 (PAGE_WORDS_LOG2),
    .LINE_BURSTS     (LINE_BURSTS),
    .BURST_BEATS     (BURST_BEATS)
  ) UUT (
    .clk             (clk),
    .sys_rst_n       (sys_rst_n),
    .bus_address     (bus_address),
    .bus_read        (bus_read),
    .bus_write       (bus_write),
    .bus_writedata   (bus_writedata),
    .bus_byteenable  (bus_byteenable),
    .bus_readdata    (bus_readdata),
    .bus_waitrequest (bus_waitrequest),
    .line_req        (line_req),
    .line_addr       (line_addr),
    .line_word       (line_word),
    .line_word_valid (line_word_valid),
    .line_done       (line_done),
    .sdram_cmd       (sdram_cmd),
    .sdram_din       (sdram_din),
    .sdram_rd_ack    (sdram_rd_ack),
    .sdram_wr_ack    (sdram_wr_ack),
    .sdram_dout      (sdram_dout)
  );

  sdram_model #(
    .MEM_ADDR_W   (MEM_ADDR_W)
  ) u_sdram_model (
    .clk          (clk),
    .sys_rst_n    (sys_rst_n),
    .sdram_cmd    (sdram_cmd),
    .sdram_din    (sdram_din),
    .sdram_rd_ack (sdram_rd_ack),
    .sdram_wr_ack (sdram_wr_ack),
    .sdram_dout   (sdram_dout)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a handshake never completed", cycle_count);
      $display("TEST FAIL");
      $finish;
    end
  end

  // port carries one direction at a time
  always @(negedge clk) begin
    if (sys_rst_n) begin
      assert (!(sdram_cmd.rd_req && sdram_cmd.wr_req))
        else begin
          $display("at %0t: SDRAM read and write requests are high together", $time);
          err_count++;
        end
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [31:0] shadow_word(input int addr);
    return {shadow16[2 * addr + 1], shadow16[2 * addr]};  // high half at 2a+1
  endfunction

  task automatic expect_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    check_count++;
    assert (got === exp)
      else begin
        $display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
        err_count++;
      end
  endtask

  task automatic close_test(input string name);
    test_count++;
    $display("test %0d %-16s done, %0d errors", test_count, name, err_count - test_err_base);
    test_err_base = err_count;
  endtask

  function automatic int held_slot(input int page);
    int found;
    found = -1;
    for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
      if (ref_tagged[i] && ref_tag[i] == page) found = i;
    end
    return found;
  endfunction

  // mirror of the life rule for one completed access
  task automatic track_access(input int addr);
    int page;
    int used;
    page = addr >> PAGE_WORDS_LOG2;
    used = held_slot(page);
    if (used < 0) begin
      for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
        if (ref_life[i] == 0) used = i;
      end
      if (used >= 0) begin  // claim, old page leaves
        ref_tagged[used] = 1'b1;
        ref_tag[used] = page;
        ref_life[used] = LIFE_START;
      end
    end
    for (int i = 0; i < SLOT_COUNT; i++) begin
      if (i == used) begin
        if (ref_life[i] < LIFE_CEILING) ref_life[i] += 2 * SLOT_COUNT;
      end else if (ref_life[i] != 0) begin
        ref_life[i]--;
      end
    end
  endtask

  task automatic bus_access(input logic wr, input int addr, input logic [31:0] wdata,
                            input logic [3:0] be, output logic [31:0] rdata, output int cycles);
    @(posedge clk);
    #1;
    bus_address = BUS_ADDR_W'(addr);
    bus_read = !wr;
    bus_write = wr;
    bus_writedata = wdata;
    bus_byteenable = be;
    @(negedge clk);
    cycles = 1;
    while (bus_waitrequest) begin
      @(negedge clk);
      cycles++;
    end
    rdata = bus_readdata;
    @(posedge clk);
    #1;
    bus_read = 1'b0;
    bus_write = 1'b0;
    track_access(addr);
  endtask

  task automatic read_and_compare(input int addr, input bit expect_hit);
    logic [31:0] rdata;
    int cycles;
    bus_access(1'b0, addr, '0, 4'hf, rdata, cycles);
    expect_value("bus_readdata", shadow_word(addr), rdata);
    if (expect_hit) expect_value("read hit cycles", 2, cycles);
  endtask

  task automatic write_merged(input int addr, input logic [31:0] data, input logic [3:0] be);
    logic [31:0] merged;
    logic [31:0] rdata;
    int cycles;
    merged = shadow_word(addr);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) merged[8 * b +: 8] = data[8 * b +: 8];
    end
    bus_access(1'b1, addr, data, be, rdata, cycles);
    shadow16[2 * addr] = merged[15:0];
    shadow16[2 * addr + 1] = merged[31:16];
  endtask

  task automatic fetch_line(input int laddr);
    int count;
    int base;
    bit done_seen;
    base = laddr * LINE_WORDS;
    count = 0;
    done_seen = 1'b0;
    @(posedge clk);
    #1;
    line_addr = LINE_ADDR_W'(laddr);
    line_req = 1'b1;
    while (!done_seen) begin
      @(negedge clk);
      if (line_word_valid) begin
        expect_value("line_word.index", count, line_word.index);
        expect_value("line_word.data", shadow16[base + count], line_word.data);
        count++;
      end
      if (line_done) begin
        expect_value("words before line_done", LINE_WORDS, count);
        done_seen = 1'b1;
      end
    end
    @(posedge clk);
    #1;
    line_req = 1'b0;
    repeat (2) @(negedge clk);
    expect_value("line_done", 0, line_done);  // drops one cycle after the request
  endtask

  task automatic check_reset_state();
    @(negedge clk);
    expect_value("bus_waitrequest", 0, bus_waitrequest);
    expect_value("line_word_valid", 0, line_word_valid);
    expect_value("line_done", 0, line_done);
    expect_value("sdram_cmd.rd_req", 0, sdram_cmd.rd_req);
    expect_value("sdram_cmd.wr_req", 0, sdram_cmd.wr_req);
  endtask

  task automatic read_untouched_words();
    read_and_compare(16, 1'b0);
    read_and_compare(19, 1'b0);
    read_and_compare(23, 1'b0);
    read_and_compare(30, 1'b0);
  endtask

  task automatic write_then_read();
    logic [31:0] data;
    draw_bits(32, data);
    write_merged(32, data, 4'hf);
    read_and_compare(32, 1'b1);
    draw_bits(32, data);
    write_merged(37, data, 4'b0110);  // outer bytes keep their old value
    read_and_compare(37, 1'b1);
  endtask

  task automatic overflow_pages();
    logic [31:0] data;
    logic [31:0] be_raw;
    int addr;
    int page;
    for (int p = 0; p < 6; p++) begin
      for (int w = 0; w < 2; w++) begin
        draw_bits(32, data);
        draw_bits(4, be_raw);
        addr = (OVF_PAGE0 + p) * PAGE_WORDS + w * 7;
        write_merged(addr, data, (w == 0) ? 4'hf : be_raw[3:0]);
      end
    end
    for (int p = 0; p < 6; p++) begin
      for (int w = 0; w < 2; w++) begin
        read_and_compare((OVF_PAGE0 + p) * PAGE_WORDS + w * 7, 1'b0);
      end
    end
    for (int p = 0; p < 6; p++) begin
      page = OVF_PAGE0 + p;
      if (held_slot(page) < 0) begin  // bypassed or evicted, SDRAM is current
        for (int w = 0; w < PAGE_WORDS; w++) begin
          addr = page * PAGE_WORDS + w;
          expect_value("sdram model word", shadow_word(addr),
                       {u_sdram_model.mem[2 * addr + 1], u_sdram_model.mem[2 * addr]});
        end
      end
    end
  endtask

  task automatic mix_line_and_reads();
    fork
      fetch_line(210);
      begin
        for (int i = 0; i < 4; i++) begin
          read_and_compare(160 + 3 * i, 1'b0);
        end
      end
    join
  endtask

  initial begin
    logic [31:0] v;
    sys_rst_n = 1'b0;
    bus_address = '0;
    bus_read = 1'b0;
    bus_write = 1'b0;
    bus_writedata = '0;
    bus_byteenable = '0;
    line_req = 1'b0;
    line_addr = '0;
    for (int i = 0; i < SLOT_COUNT; i++) begin
      ref_tag[i] = 0;
      ref_tagged[i] = 1'b0;
      ref_life[i] = 0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      draw_bits(16, v);
      shadow16[i] = v[15:0];
      u_sdram_model.preload(i, v[15:0]);
    end
    repeat (8) @(posedge clk);
    #1;
    sys_rst_n = 1'b1;

    check_reset_state();
    close_test("reset state");
    read_untouched_words();
    close_test("miss read");
    write_then_read();
    close_test("write then read");
    overflow_pages();
    close_test("evict and bypass");
    fetch_line(200);
    close_test("line fetch");
    mix_line_and_reads();
    close_test("concurrent");

    $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== sdram_cache_bridge.f ====
design/bridge_cfg_pkg.sv
design/bridge_types_pkg.sv
design/word_cache.sv
design/line_fetcher.sv
design/sdram_port_arbiter.sv
design/sdram_cache_bridge.sv
verification/sdram_model.sv
verification/tb_sdram_cache_bridge.sv

// ==== Bender.yml ====
package:
  name: sdram_cache_bridge

sources:
  - files:
      - design/bridge_cfg_pkg.sv
      - design/bridge_types_pkg.sv
      - design/word_cache.sv
      - design/line_fetcher.sv
      - design/sdram_port_arbiter.sv
      - design/sdram_cache_bridge.sv
  - target: test
    files:
      - verification/sdram_model.sv
      - verification/tb_sdram_cache_bridge.sv
